// File: Makefile
# Verilator flow for the element-wise matrix multiplier

VERILATOR  := verilator
TOP        := tb_matrix_integer_multiplier
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
SIM_ARGS   := +verilator+error+limit+100
PASS_TEXT  := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# Pass only when the testbench prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
hw/matrix_pkg.sv
hw/mul_if.sv
hw/matrix_multiplier_ctrl.sv
hw/operand_capture.sv
hw/element_multiplier.sv
hw/matrix_integer_multiplier.sv
tests/matrix_assertions.sv
tests/tb_matrix_integer_multiplier.sv

// File: hw/element_multiplier.sv
////////////////////////////////////////
// Two-stage unsigned multiplier
// Stage 1 registers the operands on issue
// Stage 2 forms the double-width product
// done follows issue by two cycles
// Words hold until the next pair arrives
////////////////////////////////////////

`timescale 1ns/10ps

module element_multiplier #(
  parameter int DATA_SIZE = matrix_pkg::DEFAULT_DATA_SIZE
) (
  input  logic CLK,
  input  logic RST,

  // Operands in, product out
  mul_if.mult  mul
);

  localparam int PRODUCT_SIZE = 2 * DATA_SIZE;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Stage 1
  logic [DATA_SIZE-1:0] a_q;
  logic [DATA_SIZE-1:0] b_q;
  logic                 valid_s1;

  // Stage 2
  logic [PRODUCT_SIZE-1:0] product_q;
  logic                    valid_s2;

  ////////////////////////////////////////
  // Valid pipe
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      valid_s1 <= mul.issue;
      valid_s2 <= valid_s1;
    end
  end

  ////////////////////////////////////////
  // Data pipe
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Operands taken with the issue pulse
    if (mul.issue) begin
      a_q <= mul.a;
      b_q <= mul.b;
    end

    // Full-width unsigned product, no truncation
    if (valid_s1) begin
      product_q <= PRODUCT_SIZE'(a_q) * PRODUCT_SIZE'(b_q);
    end
  end

  // Low word is the result, high word the overflow
  assign mul.product_lo = product_q[DATA_SIZE-1:0];
  assign mul.product_hi = product_q[PRODUCT_SIZE-1:DATA_SIZE];
  assign mul.done       = valid_s2;

endmodule

// File: hw/matrix_integer_multiplier.sv
////////////////////////////////////////
// Element-wise unsigned matrix multiplier
// DATA_OUT(i,j) = A(i,j) * B(i,j)
// data_out gets the low product word,
// overflow_out the high one
// Outputs never stall, strobes are pulses
////////////////////////////////////////

`timescale 1ns/10ps

module matrix_integer_multiplier #(
  parameter int DATA_SIZE    = matrix_pkg::DEFAULT_DATA_SIZE,
  parameter int CONTROL_SIZE = matrix_pkg::DEFAULT_CONTROL_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 start,
  output logic                 ready,

  input  logic                 data_a_in_i_enable,
  input  logic                 data_a_in_j_enable,
  input  logic                 data_b_in_i_enable,
  input  logic                 data_b_in_j_enable,
  output logic                 data_out_i_enable,
  output logic                 data_out_j_enable,

  // Data
  input  logic [DATA_SIZE-1:0] size_i_in,
  input  logic [DATA_SIZE-1:0] size_j_in,
  input  logic [DATA_SIZE-1:0] data_a_in,
  input  logic [DATA_SIZE-1:0] data_b_in,

  output logic [DATA_SIZE-1:0] data_out,
  output logic [DATA_SIZE-1:0] overflow_out
);

  logic accept;
  logic row_first;

  // Capture, multiplier and control link
  mul_if #(.DATA_SIZE(DATA_SIZE)) mul_bus ();

  matrix_multiplier_ctrl #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) ctrl_i (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_i_in        (size_i_in),
    .size_j_in        (size_j_in),
    .accept           (accept),
    .row_first        (row_first),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .mul              (mul_bus.ctrl)
  );

  operand_capture #(.DATA_SIZE(DATA_SIZE)) capture_i (
    .CLK               (CLK),
    .RST               (RST),
    .accept            (accept),
    .row_first         (row_first),
    .data_a_in_i_enable(data_a_in_i_enable),
    .data_a_in_j_enable(data_a_in_j_enable),
    .data_b_in_i_enable(data_b_in_i_enable),
    .data_b_in_j_enable(data_b_in_j_enable),
    .data_a_in         (data_a_in),
    .data_b_in         (data_b_in),
    .mul               (mul_bus.capture)
  );

  element_multiplier #(.DATA_SIZE(DATA_SIZE)) mult_i (
    .CLK(CLK),
    .RST(RST),
    .mul(mul_bus.mult)
  );

  // Result words, aligned with data_out_j_enable
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out     <= '0;
      overflow_out <= '0;
    end else if (mul_bus.done) begin
      data_out     <= mul_bus.product_lo;
      overflow_out <= mul_bus.product_hi;
    end
  end

endmodule

// File: hw/matrix_multiplier_ctrl.sv
////////////////////////////////////////
// Control FSM for the element-wise product
// Row and column loops over size_i_in and
// size_j_in, each at most 2**CONTROL_SIZE
// Sizes must be held stable and nonzero
// while a matrix is in progress
// One element in flight, no back-pressure
////////////////////////////////////////

`timescale 1ns/10ps

module matrix_multiplier_ctrl #(
  parameter int DATA_SIZE    = matrix_pkg::DEFAULT_DATA_SIZE,
  parameter int CONTROL_SIZE = matrix_pkg::DEFAULT_CONTROL_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Run control
  input  logic                 start,
  input  logic [DATA_SIZE-1:0] size_i_in,
  input  logic [DATA_SIZE-1:0] size_j_in,

  // To operand capture
  output logic                 accept,
  output logic                 row_first,

  // Result strobes
  output logic                 ready,
  output logic                 data_out_i_enable,
  output logic                 data_out_j_enable,

  // Multiplier pulses
  mul_if.ctrl                  mul
);

  import matrix_pkg::*;

  ////////////////////////////////////////
  // Constants and signals
  ////////////////////////////////////////

  localparam logic [DATA_SIZE-1:0]    ONE_DATA     = 1;
  localparam logic [CONTROL_SIZE-1:0] ONE_CONTROL  = 1;
  localparam logic [CONTROL_SIZE-1:0] ZERO_CONTROL = '0;

  ctrl_state_e state;

  // Row and column loop indices
  logic [CONTROL_SIZE-1:0] index_i;
  logic [CONTROL_SIZE-1:0] index_j;

  // Last index of each loop
  logic [DATA_SIZE-1:0] last_i_index;
  logic [DATA_SIZE-1:0] last_j_index;

  logic last_row;
  logic last_col;

  ////////////////////////////////////////
  // Loop end detection
  ////////////////////////////////////////

  assign last_i_index = size_i_in - ONE_DATA;
  assign last_j_index = size_j_in - ONE_DATA;

  // Index widened or cut to the size word
  assign last_row = (DATA_SIZE'(index_i) == last_i_index);
  assign last_col = (DATA_SIZE'(index_j) == last_j_index);

  // Capture takes strobes only while waiting
  assign accept    = (state == CTRL_ACCEPT);
  // First element of a row uses the _i_enable strobes
  assign row_first = (index_j == ZERO_CONTROL);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= CTRL_IDLE;
      index_i           <= ZERO_CONTROL;
      index_j           <= ZERO_CONTROL;
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
    end else begin
      // Output strobes last one cycle
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;

      case (state)
        CTRL_IDLE: begin
          if (start) begin
            index_i <= ZERO_CONTROL;
            index_j <= ZERO_CONTROL;
            state   <= CTRL_ACCEPT;
          end
        end

        CTRL_ACCEPT: begin
          // Pair complete, capture clears its flags on this edge
          if (mul.issue) begin
            state <= CTRL_MULTIPLY;
          end
        end

        CTRL_MULTIPLY: begin
          if (mul.done) begin
            data_out_j_enable <= 1'b1;
            data_out_i_enable <= last_col;
            ready             <= last_col && last_row;

            // Column first, then row
            if (last_col) begin
              index_j <= ZERO_CONTROL;
              if (!last_row) begin
                index_i <= index_i + ONE_CONTROL;
              end
            end else begin
              index_j <= index_j + ONE_CONTROL;
            end

            // Matrix finished, back to idle
            if (last_col && last_row) begin
              state <= CTRL_IDLE;
            end else begin
              state <= CTRL_ACCEPT;
            end
          end
        end

        default: begin
          state <= CTRL_IDLE;
        end
      endcase
    end
  end

endmodule

// File: hw/matrix_pkg.sv
////////////////////////////////////////
// Shared types and default sizes for the
// element-wise matrix multiplier
// Unsigned operands only
// Defaults are overridden at the top level
////////////////////////////////////////

package matrix_pkg;

  ////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////

  // Operand word width, two or more bits
  localparam int DEFAULT_DATA_SIZE = 16;

  // Loop index width, matrices up to 2**N per side
  localparam int DEFAULT_CONTROL_SIZE = 8;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  localparam int CTRL_STATE_BITS = 2;

  // Idle until start, then one element in flight at a time
  typedef enum logic [CTRL_STATE_BITS-1:0] {
    // Waiting for start
    CTRL_IDLE     = 2'd0,
    // Waiting for both operands of the current element
    CTRL_ACCEPT   = 2'd1,
    // Product in the multiplier pipe
    CTRL_MULTIPLY = 2'd2
  } ctrl_state_e;

endpackage

// File: hw/mul_if.sv
////////////////////////////////////////
// Link between operand capture, element
// multiplier and control FSM
// issue and done are one-cycle pulses
////////////////////////////////////////

`timescale 1ns/10ps

interface mul_if #(
  parameter int DATA_SIZE = matrix_pkg::DEFAULT_DATA_SIZE
) ();

  // Operand pair and its start pulse
  logic                 issue;
  logic [DATA_SIZE-1:0] a;
  logic [DATA_SIZE-1:0] b;

  // Split product and its valid pulse
  logic [DATA_SIZE-1:0] product_lo;
  logic [DATA_SIZE-1:0] product_hi;
  logic                 done;

  // Capture side
  modport capture(output issue, output a, output b);

  // Multiplier side
  modport mult(input issue, input a, input b, output product_lo, output product_hi, output done);

  // Control only watches the pulses
  modport ctrl(input issue, input done);

endinterface

// File: hw/operand_capture.sv
////////////////////////////////////////
// Holds one A and one B element
// Strobes count only while accept is high
// A repeated strobe overwrites the held word
// issue is high while both words are held
////////////////////////////////////////

`timescale 1ns/10ps

module operand_capture #(
  parameter int DATA_SIZE = matrix_pkg::DEFAULT_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,

  // From control
  input  logic                 accept,
  input  logic                 row_first,

  // Operand strobes
  input  logic                 data_a_in_i_enable,
  input  logic                 data_a_in_j_enable,
  input  logic                 data_b_in_i_enable,
  input  logic                 data_b_in_j_enable,

  // Operand words
  input  logic [DATA_SIZE-1:0] data_a_in,
  input  logic [DATA_SIZE-1:0] data_b_in,

  // Pair out to the multiplier
  mul_if.capture               mul
);

  logic                 a_strobe;
  logic                 b_strobe;
  logic                 a_held;
  logic                 b_held;
  logic [DATA_SIZE-1:0] a_word;
  logic [DATA_SIZE-1:0] b_word;

  // Row start uses the i strobes, the rest of the row the j strobes
  assign a_strobe = accept && (row_first ? data_a_in_i_enable : data_a_in_j_enable);
  assign b_strobe = accept && (row_first ? data_b_in_i_enable : data_b_in_j_enable);

  // Holding flags
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_held <= 1'b0;
      b_held <= 1'b0;
    end else if (mul.issue) begin
      // Pair handed over, start clean for the next element
      a_held <= 1'b0;
      b_held <= 1'b0;
    end else begin
      if (a_strobe) a_held <= 1'b1;
      if (b_strobe) b_held <= 1'b1;
    end
  end

  // Operand words
  always_ff @(posedge CLK) begin
    if (a_strobe && !mul.issue) a_word <= data_a_in;
    if (b_strobe && !mul.issue) b_word <= data_b_in;
  end

  // One cycle, flags drop on the sampling edge
  assign mul.issue = a_held && b_held;
  assign mul.a     = a_word;
  assign mul.b     = b_word;

endmodule

// File: tests/matrix_assertions.sv
////////////////////////////////////////
// Checks on the control FSM, bound into
// every matrix_multiplier_ctrl instance
// fail_count sums the failed checks
////////////////////////////////////////

`timescale 1ns/10ps

module matrix_assertions (
  input  logic                    CLK,
  input  logic                    RST,
  input  matrix_pkg::ctrl_state_e state,
  input  logic                    issue,
  input  logic                    done,
  input  logic                    ready,
  input  logic                    data_out_i_enable,
  input  logic                    data_out_j_enable,
  output int                      fail_count
);

  import matrix_pkg::*;

  int reset_fails = 0;
  int ready_fails = 0;
  int done_fails  = 0;

  assign fail_count = reset_fails + ready_fails + done_fails;

  // FSM idle and strobes low once reset has been seen
  assert property (@(posedge CLK) $past(RST) |->
      (state == CTRL_IDLE) && !ready && !data_out_i_enable && !data_out_j_enable)
    else begin
      $error("Strobes or FSM state not cleared by reset");
      reset_fails++;
    end

  // Matrix end always comes with an element
  assert property (@(posedge CLK) disable iff (RST) ready |-> data_out_j_enable)
    else begin
      $error("ready pulsed without data_out_j_enable");
      ready_fails++;
    end

  // Two-stage multiplier pipe
  assert property (@(posedge CLK) disable iff (RST) done == $past(issue, 2))
    else begin
      $error("done does not follow issue by two cycles");
      done_fails++;
    end

endmodule

bind matrix_multiplier_ctrl matrix_assertions ctrl_checks_i (
  .CLK              (CLK),
  .RST              (RST),
  .state            (state),
  .issue            (mul.issue),
  .done             (mul.done),
  .ready            (ready),
  .data_out_i_enable(data_out_i_enable),
  .data_out_j_enable(data_out_j_enable),
  .fail_count       ()
);

// File: tests/matrix_stimulus.txt
// Case header: size_i size_j mode
//   mode 0 gaps from the file, 1 random gaps, 2 strobes while idle first
// Element: a b gap b_first, one matrix row per line; header 0 0 0 ends the list
// 1 by 1
0001 0001 0000
0007 0009 0000 0000
// 3 by 4, small operands
0003 0004 0000
0001 0002 0000 0000  0003 0004 0001 0000  0005 0006 0002 0001  0007 0008 0000 0001
0010 0020 0001 0001  00ff 0101 0000 0000  0100 00ff 0003 0000  0021 0003 0002 0001
0002 7fff 0000 0000  0009 0009 0001 0001  0000 1234 0000 0000  00c8 0064 0002 0000
// 2 by 2, operands near the word limit
0002 0002 0000
ffff ffff 0000 0000  fff0 0102 0001 0001
8000 0002 0002 0000  abcd 1234 0000 0001
// 2 by 3, B before A, gap column replaced by random gaps
0002 0003 0001
1111 0002 0000 0001  0123 0045 0000 0001  0fff 000f 0000 0001
00aa 00bb 0000 0001  4000 0004 0000 0001  0033 0077 0000 0001
// 2 by 2 after strobes in idle
0002 0002 0002
0006 0007 0000 0000  0102 0201 0001 0001
fedc 0003 0002 0000  0005 1000 0000 0001
0000 0000 0000

// File: tests/tb_matrix_integer_multiplier.sv
////////////////////////////////////////
// Testbench for the element-wise multiplier
// Cases come from tests/matrix_stimulus.txt,
// path taken from the project root
// One element in flight, the next one is
// driven after the previous result pulse
////////////////////////////////////////

`timescale 1ns/10ps

module tb_matrix_integer_multiplier;

  import matrix_pkg::*;

  localparam int DATA_SIZE    = DEFAULT_DATA_SIZE;
  localparam int CONTROL_SIZE = DEFAULT_CONTROL_SIZE;
  localparam int TIMEOUT      = 100;

  typedef logic [DATA_SIZE-1:0] word_t;

  logic  CLK;
  logic  RST;
  logic  start;
  logic  data_a_in_i_enable;
  logic  data_a_in_j_enable;
  logic  data_b_in_i_enable;
  logic  data_b_in_j_enable;
  word_t size_i_in;
  word_t size_j_in;
  word_t data_a_in;
  word_t data_b_in;
  logic  ready;
  logic  data_out_i_enable;
  logic  data_out_j_enable;
  word_t data_out;
  word_t overflow_out;

  // Stimulus words in file order
  word_t      stim_mem [0:255];
  logic [7:0] stim_ptr;
  int         errors;
  int         checks;
  bit         abort;
  integer     seed;

  // Cycles each output strobe was seen high
  int         j_total;
  int         ready_total;

  matrix_integer_multiplier #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Pulse monitor, independent of the element loop
  always @(negedge CLK) begin
    if (!RST) begin
      if (data_out_j_enable) j_total++;
      if (ready) ready_total++;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_strobe(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic word_t next_word();
    next_word = stim_mem[stim_ptr];
    stim_ptr  = stim_ptr + 8'd1;
  endfunction

  task automatic clear_strobes();
    data_a_in_i_enable <= 1'b0;
    data_a_in_j_enable <= 1'b0;
    data_b_in_i_enable <= 1'b0;
    data_b_in_j_enable <= 1'b0;
  endtask

  // Row start uses the _i_enable strobes
  task automatic strobe_operand(input bit is_b, input word_t value, input bit first_col);
    if (is_b) begin
      data_b_in          <= value;
      data_b_in_i_enable <= first_col;
      data_b_in_j_enable <= !first_col;
    end else begin
      data_a_in          <= value;
      data_a_in_i_enable <= first_col;
      data_a_in_j_enable <= !first_col;
    end
  endtask

  // Gap 0 strobes both together, else gap cycles apart
  task automatic drive_element(input word_t a, input word_t b, input int gap,
                               input bit b_first, input bit first_col);
    @(posedge CLK);
    if (gap == 0) begin
      strobe_operand(1'b0, a, first_col);
      strobe_operand(1'b1, b, first_col);
    end else begin
      strobe_operand(b_first, b_first ? b : a, first_col);
      @(posedge CLK);
      clear_strobes();
      repeat (gap - 1) @(posedge CLK);
      strobe_operand(!b_first, b_first ? a : b, first_col);
    end
    @(posedge CLK);
    clear_strobes();
  endtask

  // Outputs sampled mid-cycle
  task automatic wait_result(input bit expected, output bit seen);
    int cycles;
    seen = 1'b0;
    for (cycles = 0; cycles < TIMEOUT && !seen; cycles++) begin
      @(negedge CLK);
      seen = data_out_j_enable;
    end
    if (expected && !seen) begin
      errors++;
      abort = 1'b1;
      $display("Timeout: no data_out_j_enable within %0d cycles", TIMEOUT);
    end else if (!expected && seen) begin
      errors++;
      $display("data_out_j_enable pulsed although the DUT was idle");
    end
  endtask

  ////////////////////////////////////////
  // One matrix
  ////////////////////////////////////////

  task automatic run_case(input int rows, input int cols, input int mode);
    word_t                  a;
    word_t                  b;
    word_t                  order_w;
    int                     gap;
    bit                     seen;
    int                     j_start;
    int                     ready_start;
    logic [2*DATA_SIZE-1:0] product;
    j_start     = j_total;
    ready_start = ready_total;
    @(posedge CLK);
    size_i_in <= word_t'(rows);
    size_j_in <= word_t'(cols);
    if (mode == 2) begin
      // No start yet, these strobes must be dropped
      strobe_operand(1'b0, '1, 1'b1);
      strobe_operand(1'b1, '1, 1'b1);
      @(posedge CLK);
      clear_strobes();
      wait_result(1'b0, seen);
    end
    @(posedge CLK);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
    for (int i = 0; i < rows && !abort; i++) begin
      for (int j = 0; j < cols && !abort; j++) begin
        a       = next_word();
        b       = next_word();
        gap     = int'(next_word());
        order_w = next_word();
        if (mode == 1) gap = 1 + ($random(seed) & 3);
        drive_element(a, b, gap, order_w != '0, j == 0);
        wait_result(1'b1, seen);
        if (seen) begin
          // Full-width product split into result and overflow words
          product = {{DATA_SIZE{1'b0}}, a} * {{DATA_SIZE{1'b0}}, b};
          check_word($sformatf("data_out(%0d,%0d)", i, j), data_out,
                     product[DATA_SIZE-1:0]);
          check_word($sformatf("overflow_out(%0d,%0d)", i, j), overflow_out,
                     product[2*DATA_SIZE-1:DATA_SIZE]);
          check_strobe("data_out_i_enable", data_out_i_enable, j == cols - 1);
          check_strobe("ready", ready, (i == rows - 1) && (j == cols - 1));
        end
      end
    end
    // Let the monitor see any stretched or late pulse
    repeat (2) @(posedge CLK);
    check_count("data_out_j_enable pulses", j_total - j_start, rows * cols);
    check_count("ready pulses", ready_total - ready_start, 1);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    word_t rows_w;
    word_t cols_w;
    word_t mode_w;
    int    assert_fails;
    seed        = 32'h7593_a849;
    errors      = 0;
    checks      = 0;
    abort       = 1'b0;
    stim_ptr    = '0;
    j_total     = 0;
    ready_total = 0;
    RST       <= 1'b1;
    start     <= 1'b0;
    size_i_in <= '0;
    size_j_in <= '0;
    data_a_in <= '0;
    data_b_in <= '0;
    clear_strobes();
    $readmemh("tests/matrix_stimulus.txt", stim_mem);
    repeat (16) @(posedge CLK);
    RST <= 1'b0;

    while (!abort) begin
      rows_w = next_word();
      cols_w = next_word();
      mode_w = next_word();
      if ($isunknown(rows_w)) begin
        errors++;
        $display("Stimulus data missing or without its end marker");
        break;
      end
      if (rows_w == '0) break;
      run_case(int'(rows_w), int'(cols_w), int'(mode_w));
    end

    repeat (4) @(posedge CLK);
    assert_fails = dut_i.ctrl_i.ctrl_checks_i.fail_count;
    $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
